//--- hdl/tspp_pkg.sv
/* Shared definitions for the two-stage core: data width, RV32I major opcodes,
   decoded operations, trap causes and the packed structs passed between blocks. */
package tspp_pkg;

  parameter int XLEN = 32; // Width of the data path and of every address.

  // Major opcodes of the RV32I subset, taken from insn[6:0].
  localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU group.
  localparam logic [6:0] OPC_IMM    = 7'b0010011; // Register-immediate ALU group.
  localparam logic [6:0] OPC_LOAD   = 7'b0000011; // Loads.
  localparam logic [6:0] OPC_STORE  = 7'b0100011; // Stores.
  localparam logic [6:0] OPC_BRANCH = 7'b1100011; // Conditional branches.
  localparam logic [6:0] OPC_JAL    = 7'b1101111; // Jump and link.
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // ECALL and MRET live here.

  localparam logic [XLEN-1:0] INSN_ECALL = 32'h0000_0073; // Full ECALL encoding.
  localparam logic [XLEN-1:0] INSN_MRET  = 32'h3020_0073; // Full MRET encoding.

  // Operations the execute stage knows how to run.
  typedef enum logic [3:0] {
    OP_ADD,     // rd = rs1 + rs2.
    OP_ADDI,    // rd = rs1 + imm.
    OP_LW,      // Word load.
    OP_SW,      // Word store.
    OP_BEQ,     // Branch when equal.
    OP_JAL,     // Jump, link into rd.
    OP_ECALL,   // Environment call from machine mode.
    OP_MRET,    // Return from the trap handler.
    OP_ILLEGAL  // Anything outside the subset.
  } opcode_t;

  // Trap causes with their mcause encodings.
  typedef enum logic [XLEN-1:0] {
    CAUSE_MAL_INSN  = 32'd0,        // Misaligned instruction fetch.
    CAUSE_ILLEGAL   = 32'd2,        // Illegal instruction.
    CAUSE_MAL_LOAD  = 32'd4,        // Misaligned load address.
    CAUSE_MAL_STORE = 32'd6,        // Misaligned store address.
    CAUSE_ECALL_M   = 32'd11,       // ECALL in machine mode.
    CAUSE_IRQ       = 32'h8000_000B // Machine external interrupt.
  } cause_t;

  typedef struct packed {
    logic            valid;    // A completed fetch sits in this packet.
    logic [XLEN-1:0] pc;       // Address the word was fetched from.
    logic [XLEN-1:0] insn;     // Raw instruction word.
    logic            mal_insn; // The PC was not word aligned.
  } fetch_pkt_t;

  typedef struct packed {
    logic illegal_insn; // Decode found no legal operation.
    logic mal_l;        // Load address not word aligned.
    logic mal_s;        // Store address not word aligned.
    logic env_m;        // ECALL retired in machine mode.
  } ex_exc_t;

  typedef struct packed {
    logic            valid; // One-cycle pulse per register write.
    logic [4:0]      rd;    // Destination register, never x0.
    logic [XLEN-1:0] data;  // Value written.
  } wb_t;

  typedef struct packed {
    logic            valid; // Trap request or report.
    cause_t          cause; // mcause value.
    logic [XLEN-1:0] epc;   // Address execution resumes at after MRET.
  } trap_rec_t;

endpackage

//--- hdl/fetch_stage.sv
/* Fetch stage: PC register, instruction memory request
   and detection of a misaligned fetch address. */
`timescale 1ns/1ps

module fetch_stage import tspp_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0 // First address fetched after reset.
) (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            pc_en,       // Update the PC at this edge.
  input  logic            npc_sel,     // Take next_target instead of pc + 4.
  input  logic [XLEN-1:0] next_target, // Redirect address from the hazard unit.
  input  logic            iren,        // Fetch permitted this cycle.
  output logic            imem_ren,
  output logic [XLEN-1:0] imem_addr,
  input  logic [XLEN-1:0] imem_rdata,
  input  logic            imem_busy,
  output fetch_pkt_t      pkt,         // Toward the fetch/execute latch.
  output logic [XLEN-1:0] epc_f,       // Fetch PC for interrupt and fetch traps.
  output logic            mal_insn
);

  logic [XLEN-1:0] pc;      // Address of the instruction being fetched.
  logic [XLEN-1:0] pc_next; // Value the PC takes when enabled.
  logic            fetch_done;

  // Only word-aligned addresses are legal in RV32I without the C extension.
  assign mal_insn = |pc[1:0];

  // A misaligned PC never reaches the memory, so no bogus word comes back.
  assign imem_ren  = iren & ~mal_insn;
  assign imem_addr = pc; // The PC only moves on pc_en, which keeps the address stable.

  // The word is ready in the first cycle with the request up and busy low.
  assign fetch_done = imem_ren & ~imem_busy;

  assign pc_next = npc_sel ? next_target : pc + XLEN'(4);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC; // Request goes out in the first cycle after reset.
    end else if (pc_en) begin
      pc <= pc_next;  // Sequential advance or a redirect.
    end
  end

  always_comb begin
    pkt.valid    = fetch_done; // Bubble while the memory is still busy.
    pkt.pc       = pc;
    pkt.insn     = imem_rdata;
    pkt.mal_insn = mal_insn;
  end

  assign epc_f = pc; // Where execution resumes if a trap is taken here.

endmodule

//--- hdl/if_ex_latch.sv
/* Pipeline register between fetch and execute,
   holding on stall and emptying on flush. */
`timescale 1ns/1ps

module if_ex_latch import tspp_pkg::*; (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       stall,   // Keep the current packet.
  input  logic       flush,   // Replace the packet with a bubble.
  input  fetch_pkt_t in_pkt,  // From the fetch stage.
  output fetch_pkt_t out_pkt  // To the execute stage.
);

  // Flush wins over stall, since a redirect must kill the held instruction.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      out_pkt <= '0;     // Execute starts with an invalid packet.
    end else if (flush) begin
      out_pkt <= '0;     // Wrong-path or trapped instruction dropped.
    end else if (!stall) begin
      out_pkt <= in_pkt; // A fetch bubble also passes through here.
    end
  end

endmodule

//--- hdl/execute_stage.sv
/* Execute stage: decode, register file, adder, BEQ and JAL resolution,
   data memory access and detection of execute exceptions. */
`timescale 1ns/1ps

module execute_stage import tspp_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  fetch_pkt_t      pkt,          // Instruction from the latch.
  input  logic            wb_enable,    // Hazard unit lets this instruction retire.
  output logic            dmem_ren,
  output logic            dmem_wen,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  input  logic [XLEN-1:0] dmem_rdata,
  input  logic            dmem_busy,
  output logic            dren,         // A load is on the bus.
  output logic            dwen,         // A store is on the bus.
  output logic            jump,
  output logic            branch_taken,
  output logic [XLEN-1:0] target,       // Redirect address for BEQ or JAL.
  output ex_exc_t         exc,
  output logic [XLEN-1:0] epc_e,
  output logic            is_mret,
  output wb_t             wb
);

  logic [6:0]      opc;
  logic [4:0]      rd, rs1, rs2;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  opcode_t         op;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_j;
  logic [XLEN-1:0] rs1_val, rs2_val, opb, sum, wr_data;
  logic            writes_rd, retire_wr, wb_valid;
  logic [4:0]      wb_rd;
  logic [XLEN-1:0] wb_data;
  logic [XLEN-1:0] rf [32]; // Entry 0 is never written and never read.

  assign opc    = pkt.insn[6:0];
  assign rd     = pkt.insn[11:7];
  assign funct3 = pkt.insn[14:12];
  assign rs1    = pkt.insn[19:15];
  assign rs2    = pkt.insn[24:20];
  assign funct7 = pkt.insn[31:25];

  assign imm_i = {{20{pkt.insn[31]}}, pkt.insn[31:20]};
  assign imm_s = {{20{pkt.insn[31]}}, pkt.insn[31:25], pkt.insn[11:7]};
  assign imm_b = {{19{pkt.insn[31]}}, pkt.insn[31], pkt.insn[7], pkt.insn[30:25],
                  pkt.insn[11:8], 1'b0};
  assign imm_j = {{11{pkt.insn[31]}}, pkt.insn[31], pkt.insn[19:12], pkt.insn[20],
                  pkt.insn[30:21], 1'b0};

  always_comb begin
    op = OP_ILLEGAL; // Every encoding outside the subset ends here.
    case (opc)
      OPC_OP:     if (funct3 == 3'b000 && funct7 == 7'b0) op = OP_ADD;
      OPC_IMM:    if (funct3 == 3'b000) op = OP_ADDI;
      OPC_LOAD:   if (funct3 == 3'b010) op = OP_LW;
      OPC_STORE:  if (funct3 == 3'b010) op = OP_SW;
      OPC_BRANCH: if (funct3 == 3'b000) op = OP_BEQ;
      OPC_JAL:    op = OP_JAL;
      OPC_SYSTEM: begin
        if (pkt.insn == INSN_ECALL) op = OP_ECALL;
        else if (pkt.insn == INSN_MRET) op = OP_MRET;
      end
      default:    op = OP_ILLEGAL;
    endcase
  end

  // x0 is hardwired to zero on the read side.
  assign rs1_val = (rs1 == 5'd0) ? '0 : rf[rs1];
  assign rs2_val = (rs2 == 5'd0) ? '0 : rf[rs2];

  // One adder serves ADD, ADDI and the load/store address.
  assign opb = (op == OP_ADD) ? rs2_val : (op == OP_SW) ? imm_s : imm_i;
  assign sum = rs1_val + opb;

  assign exc.illegal_insn = pkt.valid & (op == OP_ILLEGAL);
  assign exc.mal_l        = pkt.valid & (op == OP_LW) & (|sum[1:0]);
  assign exc.mal_s        = pkt.valid & (op == OP_SW) & (|sum[1:0]);
  assign exc.env_m        = pkt.valid & (op == OP_ECALL);

  // A misaligned access never reaches the bus.
  assign dren       = pkt.valid & (op == OP_LW) & ~exc.mal_l;
  assign dwen       = pkt.valid & (op == OP_SW) & ~exc.mal_s;
  assign dmem_ren   = dren;
  assign dmem_wen   = dwen;
  assign dmem_addr  = sum;
  assign dmem_wdata = rs2_val;

  assign jump         = pkt.valid & (op == OP_JAL);
  assign branch_taken = pkt.valid & (op == OP_BEQ) & (rs1_val == rs2_val);
  assign target       = pkt.pc + ((op == OP_JAL) ? imm_j : imm_b);
  assign is_mret      = pkt.valid & (op == OP_MRET);
  assign epc_e        = pkt.pc;

  assign wr_data   = (op == OP_LW) ? dmem_rdata : (op == OP_JAL) ? pkt.pc + XLEN'(4) : sum;
  assign writes_rd = pkt.valid & (op inside {OP_ADD, OP_ADDI, OP_LW, OP_JAL});
  // A load only reaches here once the hazard unit sees dmem_busy low.
  assign retire_wr = wb_enable & writes_rd & (rd != 5'd0) & ~(|exc) & ~(dren & dmem_busy);

  always_ff @(posedge CLK) begin
    if (retire_wr) begin
      rf[rd]  <= wr_data;
      wb_rd   <= rd;      // Kept for the retirement report.
      wb_data <= wr_data;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) wb_valid <= 1'b0;
    else        wb_valid <= retire_wr; // One-cycle pulse after each write.
  end

  assign wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

//--- hdl/hazard_unit.sv
/* Hazard unit: PC enable and select, latch stall and flush,
   write-back enable and the choice of trap cause and epc. */
`timescale 1ns/1ps

module hazard_unit import tspp_pkg::*; (
  input  logic            dren,
  input  logic            dwen,
  input  logic            dmem_busy,
  input  logic            imem_ren,
  input  logic            imem_busy,
  input  logic            jump,
  input  logic            branch_taken,
  input  logic [XLEN-1:0] target,
  input  ex_exc_t         exc,
  input  logic [XLEN-1:0] epc_e,
  input  logic [XLEN-1:0] epc_f,
  input  logic            mal_insn,
  input  logic            is_mret,
  input  logic            intr_pending,
  input  logic            insert_pc,    // Trap unit redirects fetch this cycle.
  input  logic [XLEN-1:0] priv_pc,
  output logic            pc_en,
  output logic            npc_sel,
  output logic [XLEN-1:0] next_target,
  output logic            iren,
  output logic            if_ex_stall,
  output logic            if_ex_flush,
  output logic            wb_enable,
  output trap_rec_t       trap_req,
  output logic            ret_take
);

  logic dmem_access, wait_for_dmem, fetch_done, branch_jump;
  logic e_ex_stage, e_f_stage, intr, f_trap, trap_take;

  assign dmem_access   = dren | dwen;
  assign wait_for_dmem = dmem_access & dmem_busy; // Execute cannot retire yet.
  assign fetch_done    = imem_ren & ~imem_busy;
  assign branch_jump   = jump | branch_taken;     // Always predicted not taken.

  // Exceptions found in execute are taken at once. Fetch-side traps wait for the data bus.
  assign e_ex_stage = |exc;
  assign e_f_stage  = mal_insn & ~branch_jump & ~is_mret & ~insert_pc; // Wrong path ignored.
  assign intr       = intr_pending & ~e_ex_stage & ~e_f_stage & ~is_mret & ~insert_pc;
  assign f_trap     = (e_f_stage | intr) & ~wait_for_dmem;
  assign trap_take  = e_ex_stage | f_trap;
  assign ret_take   = is_mret;

  always_comb begin
    trap_req.valid = trap_take;
    if (exc.illegal_insn)  trap_req.cause = CAUSE_ILLEGAL;
    else if (exc.mal_l)    trap_req.cause = CAUSE_MAL_LOAD;
    else if (exc.mal_s)    trap_req.cause = CAUSE_MAL_STORE;
    else if (exc.env_m)    trap_req.cause = CAUSE_ECALL_M;
    else if (e_f_stage)    trap_req.cause = CAUSE_MAL_INSN;
    else                   trap_req.cause = CAUSE_IRQ;
    // A retiring jump means the fetch PC is stale, so its target is the resume point.
    if (e_ex_stage)        trap_req.epc = epc_e;
    else if (branch_jump)  trap_req.epc = target;
    else                   trap_req.epc = epc_f;
  end

  // No request while anything will redirect fetch, so the address never moves under busy.
  assign iren = ~(intr_pending | insert_pc | branch_jump | e_ex_stage | is_mret);

  assign npc_sel     = insert_pc | branch_jump;
  assign next_target = insert_pc ? priv_pc : target;
  assign pc_en       = insert_pc | branch_jump | (fetch_done & ~wait_for_dmem);

  assign if_ex_stall = wait_for_dmem; // An unfinished fetch is a bubble, not a stall.
  assign if_ex_flush = trap_take | ret_take | branch_jump | insert_pc;
  assign wb_enable   = ~wait_for_dmem; // Execute blocks the write itself on an exception.

endmodule

//--- hdl/trap_unit.sv
/* Machine trap state: in-handler bit, mepc and mcause,
   trap vector insertion and the MRET return path. */
`timescale 1ns/1ps

module trap_unit import tspp_pkg::*; #(
  parameter logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100 // Handler entry address.
) (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            irq,          // Level-sensitive external interrupt.
  input  trap_rec_t       trap_req,     // From the hazard unit.
  input  logic            ret_take,     // MRET retires this cycle.
  output logic            intr_pending,
  output logic            insert_pc,    // Redirect fetch to priv_pc.
  output logic [XLEN-1:0] priv_pc,
  output trap_rec_t       trap          // Report of the trap just recorded.
);

  logic            in_handler; // Set between trap entry and MRET.
  logic            trap_valid;
  logic [XLEN-1:0] mepc;
  cause_t          mcause;

  assign intr_pending = irq & ~in_handler; // No nesting of interrupts.

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      in_handler <= 1'b0;
      insert_pc  <= 1'b0;
      trap_valid <= 1'b0;
    end else begin
      insert_pc  <= trap_req.valid | ret_take; // Fetch is redirected one cycle later.
      trap_valid <= trap_req.valid;
      if (trap_req.valid) in_handler <= 1'b1;
      else if (ret_take)  in_handler <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (trap_req.valid) begin
      mepc   <= trap_req.epc;
      mcause <= trap_req.cause;
    end
  end

  // Entry goes to the vector and a return goes back to the saved epc.
  assign priv_pc = in_handler ? TRAP_VECTOR : mepc;

  always_comb begin
    trap.valid = trap_valid;
    trap.cause = mcause;
    trap.epc   = mepc;
  end

endmodule

//--- hdl/tspp_core.sv
/* Top level of the two-stage core: fetch, latch and execute
   chained together with the hazard and trap units alongside. */
`timescale 1ns/1ps

module tspp_core import tspp_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC    = '0,
  parameter logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100
) (
  input  logic            CLK,
  input  logic            rst_n,
  output logic            imem_ren,
  output logic [XLEN-1:0] imem_addr,
  input  logic [XLEN-1:0] imem_rdata,
  input  logic            imem_busy,
  output logic            dmem_ren,
  output logic            dmem_wen,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  input  logic [XLEN-1:0] dmem_rdata,
  input  logic            dmem_busy,
  input  logic            irq,
  output wb_t             wb,
  output trap_rec_t       trap
);

  fetch_pkt_t      f_pkt, x_pkt;               // Before and after the latch.
  logic [XLEN-1:0] epc_f, epc_e, target, next_target, priv_pc;
  logic            mal_insn, pc_en, npc_sel, iren, if_ex_stall, if_ex_flush;
  logic            dren, dwen, jump, branch_taken, is_mret, wb_enable;
  logic            intr_pending, insert_pc, ret_take;
  ex_exc_t         exc;
  trap_rec_t       trap_req;

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .CLK, .rst_n, .pc_en, .npc_sel, .next_target, .iren, .imem_ren, .imem_addr,
    .imem_rdata, .imem_busy, .pkt(f_pkt), .epc_f, .mal_insn
  );

  if_ex_latch u_latch (
    .CLK, .rst_n, .stall(if_ex_stall), .flush(if_ex_flush), .in_pkt(f_pkt), .out_pkt(x_pkt)
  );

  execute_stage u_execute (
    .CLK, .rst_n, .pkt(x_pkt), .wb_enable, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_wdata,
    .dmem_rdata, .dmem_busy, .dren, .dwen, .jump, .branch_taken, .target, .exc, .epc_e,
    .is_mret, .wb
  );

  hazard_unit u_hazard (
    .dren, .dwen, .dmem_busy, .imem_ren, .imem_busy, .jump, .branch_taken, .target, .exc,
    .epc_e, .epc_f, .mal_insn, .is_mret, .intr_pending, .insert_pc, .priv_pc, .pc_en,
    .npc_sel, .next_target, .iren, .if_ex_stall, .if_ex_flush, .wb_enable, .trap_req,
    .ret_take
  );

  trap_unit #(.TRAP_VECTOR(TRAP_VECTOR)) u_trap (
    .CLK, .rst_n, .irq, .trap_req, .ret_take, .intr_pending, .insert_pc, .priv_pc, .trap
  );

endmodule

//--- testbench/tspp_assertions.sv
/* Protocol properties of the core's memory and trap ports, bound to tspp_core. */
`timescale 1ns/1ps

module tspp_assertions import tspp_pkg::*; #(
  parameter logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100
) (
  input logic            CLK,
  input logic            rst_n,
  input logic            dmem_ren,
  input logic            dmem_wen,
  input logic            imem_ren,
  input logic            imem_busy,
  input logic [XLEN-1:0] imem_addr,
  input trap_rec_t       trap
);

  // A data access is either a load or a store.
  a_one_dmem_op: assert property (@(posedge CLK) disable iff (!rst_n)
    !(dmem_ren && dmem_wen)) else $error("dmem_ren and dmem_wen both high");

  // The fetch address may not move while the memory is busy.
  a_imem_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    (imem_ren && imem_busy) |=> (imem_addr == $past(imem_addr)))
    else $error("imem_addr changed during a busy fetch");

  // Trap entry goes straight to the handler.
  a_trap_vector: assert property (@(posedge CLK) disable iff (!rst_n)
    trap.valid |=> (imem_ren && imem_addr == TRAP_VECTOR))
    else $error("no fetch from the trap vector after a trap");

endmodule

bind tspp_core tspp_assertions #(.TRAP_VECTOR(TRAP_VECTOR)) u_assertions (.*);

//--- testbench/tspp_tb.sv
/* Testbench for the two-stage core: clock, reset, instruction and data memory
   models driven from the trace file, and in-order checking of W, S and T events. */
`timescale 1ns/1ps

module tspp_tb import tspp_pkg::*; ();

  localparam logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100; // Handler entry where MRET sits.
  localparam logic [XLEN-1:0] INSN_NOP    = 32'h0000_0013; // addi x0, x0, 0.
  localparam int              MAX_CYCLES  = 2000;          // Limit for the main event loop.

  logic            CLK, rst_n, irq;
  logic            imem_ren, imem_busy, dmem_ren, dmem_wen, dmem_busy;
  logic [XLEN-1:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  wb_t             wb;
  trap_rec_t       trap;

  logic [XLEN-1:0] imem [256];   // Program image indexed by word.
  logic [XLEN-1:0] dmem [256];   // Data memory indexed by word.
  int              ibusy [256];  // Wait cycles of a fetch from each word.
  int              dbusy_q [$];  // Wait cycles of each data access, in order.
  byte             exp_kind [$]; // Kind of each expected event (W, S or T).
  logic [XLEN-1:0] exp_a [$], exp_b [$];
  logic [XLEN-1:0] irq_addr;     // Fetch address that raises irq.
  int              seed = 20330;
  int              iwait, dwait, dwant, errors, checks, cycles;
  logic            i_was_busy, d_was_busy, d_was_done, irq_next, irq_done;

  // Memory models answer from the current address; busy counts cycles of one access.
  assign imem_rdata = imem[imem_addr[9:2]];
  assign imem_busy  = imem_ren && (iwait < ibusy[imem_addr[9:2]]);
  assign dmem_rdata = dmem[dmem_addr[9:2]];
  assign dmem_busy  = (dmem_ren || dmem_wen) && (dwait < dwant);

  tspp_core #(.RESET_PC(32'h0), .TRAP_VECTOR(TRAP_VECTOR)) u_dut (.*);

  always #5 CLK = ~CLK; // 10 ns period.

  function automatic int next_dmem_wait();
    if (dbusy_q.size() > 0) return dbusy_q.pop_front(); // Fixed by the trace.
    return $unsigned($random(seed)) % 4;                 // Random padding.
  endfunction

  task automatic load_trace();
    int              fd, n, c;
    logic [XLEN-1:0] a, b;
    string           kind, line;
    fd = $fopen("testbench/tspp_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the trace file");
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", kind);
      if (n == 1) begin
        if (kind.getc(0) == "#") n = $fgets(line, fd); // Comment up to end of line.
        else if (kind == "P") begin
          n = $fscanf(fd, "%h %h %d", a, b, c);
          imem[a[9:2]]  = b;
          ibusy[a[9:2]] = c;
        end else if (kind == "D") begin
          n = $fscanf(fd, "%d", c);
          dbusy_q.push_back(c);
        end else if (kind == "I") n = $fscanf(fd, "%h", irq_addr);
        else begin
          n = $fscanf(fd, "%h %h", a, b);
          exp_kind.push_back(kind.getc(0));
          exp_a.push_back(a);
          exp_b.push_back(b);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic compare_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] got);
    checks++;
    assert (exp === got) else begin
      errors++;
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Matches one observed event against the head of the expected queue.
  task automatic check_event(input byte kind, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
    byte ek;
    assert (exp_kind.size() > 0) else begin
      errors++;
      $display("Unexpected %c event at %0t ns after the last expected one", kind, $time);
      return;
    end
    ek = exp_kind.pop_front();
    assert (ek == kind) else begin
      errors++;
      $display("Event order wrong at %0t ns: expected %c, saw %c", $time, ek, kind);
    end
    case (kind)
      "W":     compare_value("wb.rd", exp_a.pop_front(), a);
      "S":     compare_value("dmem_addr", exp_a.pop_front(), a);
      default: compare_value("trap.cause", exp_a.pop_front(), a);
    endcase
    case (kind)
      "W":     compare_value("wb.data", exp_b.pop_front(), b);
      "S":     compare_value("dmem_wdata", exp_b.pop_front(), b);
      default: compare_value("trap.epc", exp_b.pop_front(), b);
    endcase
  endtask

  // Looks at the settled outputs in the middle of the cycle.
  task automatic observe();
    i_was_busy = imem_ren && imem_busy;
    d_was_busy = (dmem_ren || dmem_wen) && dmem_busy;
    d_was_done = (dmem_ren || dmem_wen) && !dmem_busy;
    if (wb.valid) check_event("W", XLEN'(wb.rd), wb.data);
    if (dmem_wen && !dmem_busy) begin
      dmem[dmem_addr[9:2]] = dmem_wdata;
      check_event("S", dmem_addr, dmem_wdata);
    end
    if (trap.valid) begin
      check_event("T", trap.cause, trap.epc);
      if (trap.cause == CAUSE_IRQ) begin
        irq_next = 1'b0;
        irq_done = 1'b1;
      end else imem[trap.epc[9:2]] = INSN_NOP; // Handler patches the faulting word.
    end
    if (!irq_done && imem_ren && imem_addr == irq_addr) irq_next = 1'b1;
  endtask

  task automatic step_cycle();
    @(posedge CLK);
    #1;
    iwait = i_was_busy ? iwait + 1 : 0;
    if (d_was_busy) dwait++;
    else if (d_was_done) begin
      dwait = 0;
      dwant = next_dmem_wait(); // Wait cycles of the next access.
    end
    irq = irq_next;
    #4;
    observe();
  endtask

  initial begin
    CLK = 1'b0;
    rst_n = 1'b0;
    irq = 1'b0;
    irq_next = 1'b0;
    irq_done = 1'b0;
    irq_addr = '1;
    iwait = 0;
    dwait = 0;
    errors = 0;
    checks = 0;
    i_was_busy = 1'b0;
    d_was_busy = 1'b0;
    d_was_done = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i]  = {i[24:0], 7'h00};          // Opcode 0 is illegal everywhere.
      dmem[i]  = 32'h5A00_0000 | (i << 2); // Each word tagged with its address.
      ibusy[i] = 0;
    end
    load_trace();
    dwant = next_dmem_wait();
    repeat (16) @(posedge CLK);
    #1 rst_n = 1'b1;
    #4;
    compare_value("dmem_ren", '0, XLEN'(dmem_ren));
    compare_value("dmem_wen", '0, XLEN'(dmem_wen));
    compare_value("wb.valid", '0, XLEN'(wb.valid));
    compare_value("trap.valid", '0, XLEN'(trap.valid));
    compare_value("imem_ren", XLEN'(1), XLEN'(imem_ren));
    compare_value("imem_addr", '0, imem_addr);
    observe();
    cycles = 0;
    while (exp_kind.size() > 0 && cycles < MAX_CYCLES) begin
      step_cycle();
      cycles++;
    end
    assert (exp_kind.size() == 0) else begin
      errors++;
      $display("Timeout with %0d expected events never seen", exp_kind.size());
    end
    repeat (20) step_cycle(); // Any extra event here is reported as unexpected.
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- testbench/tspp_trace.txt
# P addr word imem_busy | D dmem_busy (per access, in order) | I irq fetch address
# W rd data | S addr data | T cause epc  (expected events, in order, hex)
P 00000000 00500093 0
P 00000004 ffd00113 0
P 00000008 002081b3 1
P 0000000c 00708013 0
P 00000010 04302023 0
P 00000014 04102223 0
P 00000018 04002203 0
P 0000001c 04402283 2
P 00000020 00520333 0
P 00000024 00320663 0
P 00000028 00100393 0
P 0000002c 00200393 0
P 00000030 0100046f 0
P 00000034 00300393 0
P 00000040 ffffffff 0
P 00000044 00102483 1
P 00000048 001021a3 0
P 0000004c 00000073 0
P 00000050 00900513 0
P 00000054 00150593 2
P 00000058 04b02423 0
P 0000005c 0000006f 0
P 00000100 30200073 0
D 2
D 0
D 3
I 00000054
W 01 00000005
W 02 fffffffd
W 03 00000002
S 00000040 00000002
S 00000044 00000005
W 04 00000002
W 05 00000005
W 06 00000007
W 08 00000034
T 00000002 00000040
T 00000004 00000044
T 00000006 00000048
T 0000000b 0000004c
W 0a 00000009
T 8000000b 00000054
W 0b 0000000a
S 00000048 0000000a

//--- list.f
hdl/tspp_pkg.sv
hdl/fetch_stage.sv
hdl/if_ex_latch.sv
hdl/execute_stage.sv
hdl/hazard_unit.sv
hdl/trap_unit.sv
hdl/tspp_core.sv
testbench/tspp_assertions.sv
testbench/tspp_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the core and its testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tspp_tb -f list.f \
  --Mdir obj_dir -o tspp_sim
./obj_dir/tspp_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  exit 0
fi
exit 1
